/* sim.f */
+incdir+source
source/memPkg.sv
source/memArbiter.sv
source/byteSequencer.sv
source/byteRam.sv
source/memSubsystem.sv
testbench/clockGen.sv
testbench/memChecker.sv
testbench/memSubsystemTb.sv

/* source/byteRam.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module byteRam
    import memPkg::*;
(
    input  logic       clk,
    input  ramPort     ram,
    output logic [7:0] rdata
);
    localparam int Depth = 1 << `RAM_ADDR_W;

    logic [7:0] mem [0:Depth-1];

    initial begin
        for (int i = 0; i < Depth; i++) begin
            mem[i] = 8'h00;
        end
    end

    // read returns the old byte on a write to the same address
    always_ff @(posedge clk) begin
        if (ram.we) begin
            mem[ram.addr] <= ram.wbyte;
        end
        rdata <= mem[ram.addr];
    end

endmodule

/* source/byteSequencer.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module byteSequencer
    import memPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       step,
    input  memReq      curReq,
    input  logic [7:0] ramRdata,
    output ramPort     ram,
    output memResp     seqResp
);
    logic [`LEN_W-1:0]  stage;
    logic               active;
    logic               run;
    logic               lastStage;
    logic               doneReg;
    logic [`DATA_W-1:0] respData;

    // assembly of load bytes
    logic [`DATA_W-1:0] asmWord;
    logic [`DATA_W-1:0] merged;
    logic [1:0]         rdLane;
    logic               rdValid;

    assign run       = start || active;
    assign lastStage = (stage == curReq.len);

    // one byte cycle per stage below len
    always_comb begin
        ram.addr  = curReq.addr + `RAM_ADDR_W'(stage);
        ram.we    = run && step && !lastStage && curReq.isStore;
        ram.wbyte = 8'(curReq.wdata >> {stage, 3'b000});
    end

    // byte read last edge lands in its lane
    always_comb begin
        merged = asmWord;
        if (rdValid) begin
            merged[{rdLane, 3'b000} +: 8] = ramRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage   <= '0;
            active  <= 1'b0;
            doneReg <= 1'b0;
            rdValid <= 1'b0;
        end else begin
            doneReg <= 1'b0;
            rdValid <= run && !lastStage && !curReq.isStore;
            if (start) begin
                active <= 1'b1;
            end
            if (step && run) begin
                if (lastStage) begin
                    stage   <= '0;
                    active  <= 1'b0;
                    doneReg <= 1'b1;
                end else begin
                    stage <= stage + 1'b1;
                end
            end
        end
    end

    // a stalled stage rereads the same byte into the same lane
    always_ff @(posedge clk) begin
        asmWord <= merged;
        if (start) begin
            asmWord <= '0;
        end
        rdLane <= stage[1:0];
        if (step && run && lastStage) begin
            respData <= merged;
        end
    end

    assign seqResp.done  = doneReg;
    assign seqResp.rdata = respData;

    weOnlyOnStore: assert property (@(posedge clk) disable iff (rst)
        ram.we |-> curReq.isStore && (start || $stable(curReq)));

    stageInRange: assert property (@(posedge clk) disable iff (rst)
        run |-> stage <= curReq.len);

endmodule

/* source/memArbiter.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module memArbiter
    import memPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   ioFull,
    input  logic                   fetchEn,
    input  logic [`RAM_ADDR_W-1:0] fetchAddr,
    input  logic                   dataEn,
    input  memReq                  dataReq,
    input  memResp                 seqResp,
    output logic                   start,
    output logic                   step,
    output memReq                  curReq,
    output grantOwner              owner,
    output memResp                 fetchResp,
    output memResp                 dataResp,
    output logic                   fetchBusy,
    output logic                   dataBusy
);
    memReq fetchReq;
    logic  idle;
    logic  grant;

    assign step  = rdy && !ioFull;
    assign idle  = (owner == ownNone);
    assign grant = idle && step && (dataEn || fetchEn);

    always_comb begin
        fetchReq.addr    = fetchAddr;
        fetchReq.wdata   = '0;
        fetchReq.len     = `LEN_W'(`FETCH_LEN);
        fetchReq.isStore = 1'b0;
    end

    // data side wins a tie
    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= ownNone;
            start <= 1'b0;
        end else begin
            start <= grant;
            if (grant) begin
                owner <= dataEn ? ownData : ownFetch;
            end else if (seqResp.done) begin
                owner <= ownNone;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            curReq <= dataEn ? dataReq : fetchReq;
        end
    end

    // response goes back only to the side holding the ram
    always_comb begin
        fetchResp.done  = seqResp.done && (owner == ownFetch);
        fetchResp.rdata = (owner == ownFetch) ? seqResp.rdata : '0;
        dataResp.done   = seqResp.done && (owner == ownData);
        dataResp.rdata  = (owner == ownData) ? seqResp.rdata : '0;
    end

    assign fetchBusy = !idle;
    assign dataBusy  = !idle;

    startWhileIdle: assert property (@(posedge clk) disable iff (rst)
        start |-> !seqResp.done);

    doneHasOwner: assert property (@(posedge clk) disable iff (rst)
        seqResp.done |-> owner != ownNone);

endmodule

/* source/memPkg.sv */
`include "mem_consts.svh"

package memPkg;

    // one load, store or fetch
    typedef struct packed {
        logic [`RAM_ADDR_W-1:0] addr;
        logic [`DATA_W-1:0]     wdata;
        logic [`LEN_W-1:0]      len;
        logic                   isStore;
    } memReq;

    // done is a single-cycle pulse, rdata valid with it
    typedef struct packed {
        logic               done;
        logic [`DATA_W-1:0] rdata;
    } memResp;

    typedef struct packed {
        logic [`RAM_ADDR_W-1:0] addr;
        logic                   we;
        logic [7:0]             wbyte;
    } ramPort;

    typedef enum logic [1:0] {
        ownNone  = 2'b00,
        ownFetch = 2'b01,
        ownData  = 2'b10
    } grantOwner;

endpackage

/* source/memSubsystem.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module memSubsystem
    import memPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   ioFull,
    input  logic                   fetchEn,
    input  logic [`RAM_ADDR_W-1:0] fetchAddr,
    input  logic                   dataEn,
    input  memReq                  dataReq,
    output memResp                 fetchResp,
    output memResp                 dataResp,
    output logic                   fetchBusy,
    output logic                   dataBusy
);
    logic       start;
    logic       step;
    memReq      curReq;
    memResp     seqResp;
    ramPort     ram;
    logic [7:0] ramRdata;

    memArbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .ioFull    (ioFull),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .dataEn    (dataEn),
        .dataReq   (dataReq),
        .seqResp   (seqResp),
        .start     (start),
        .step      (step),
        .curReq    (curReq),
        .owner     (),
        .fetchResp (fetchResp),
        .dataResp  (dataResp),
        .fetchBusy (fetchBusy),
        .dataBusy  (dataBusy)
    );

    byteSequencer u_sequencer (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .step     (step),
        .curReq   (curReq),
        .ramRdata (ramRdata),
        .ram      (ram),
        .seqResp  (seqResp)
    );

    byteRam u_ram (
        .clk   (clk),
        .ram   (ram),
        .rdata (ramRdata)
    );

endmodule

/* source/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// byte address width of the ram (4096 bytes)
`define RAM_ADDR_W 12

// word width seen by both requesters
`define DATA_W 32

// byte count field, holds 1, 2 or 4
`define LEN_W 3

// instruction fetch is always a full word
`define FETCH_LEN 4

`endif

/* testbench/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
    parameter int HalfPeriod  = 4,
    parameter int ResetCycles = 8
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(HalfPeriod) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* testbench/memChecker.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module memChecker
    import memPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   ioFull,
    input  logic                   fetchEn,
    input  logic [`RAM_ADDR_W-1:0] fetchAddr,
    input  logic                   dataEn,
    input  memReq                  dataReq,
    input  memResp                 fetchResp,
    input  memResp                 dataResp,
    input  logic                   fetchBusy,
    input  logic                   dataBusy,
    output int                     errorCount,
    output int                     checkCount,
    output int                     doneCount
);
    logic [7:0] model [0:(1 << `RAM_ADDR_W)-1];
    logic       pending;
    grantOwner  expOwner;
    memReq      expReq;
    int         cycles;
    int         stalls;

    initial begin
        for (int i = 0; i < (1 << `RAM_ADDR_W); i++) begin
            model[i] = 8'h00;
        end
        errorCount = 0;
        checkCount = 0;
        doneCount  = 0;
        pending    = 1'b0;
    end

    // little-endian, zero above len bytes
    function automatic logic [`DATA_W-1:0] modelWord(input logic [`RAM_ADDR_W-1:0] base,
                                                     input int len);
        logic [`DATA_W-1:0]     w;
        logic [`RAM_ADDR_W-1:0] a;
        w = '0;
        for (int i = 0; i < len; i++) begin
            a = base + `RAM_ADDR_W'(i);
            w[i*8 +: 8] = model[a];
        end
        return w;
    endfunction

    task automatic applyStore(input memReq r);
        logic [`RAM_ADDR_W-1:0] a;
        for (int i = 0; i < r.len; i++) begin
            a = r.addr + `RAM_ADDR_W'(i);
            model[a] = r.wdata[i*8 +: 8];
        end
    endtask

    task automatic compareValue(input string name, input logic [`DATA_W-1:0] expVal,
                                input logic [`DATA_W-1:0] gotVal);
        checkCount++;
        if (gotVal !== expVal) begin
            errorCount++;
            $display("MISMATCH %s expected=%h got=%h time=%0t", name, expVal, gotVal, $time);
        end
    endtask

    task automatic finishTransaction();
        int expLat;
        expLat = expReq.len + 1 + stalls;
        doneCount++;
        compareValue("doneLatency", expLat, cycles);
        if (expOwner == ownData) begin
            compareValue("dataResp.done", 1, dataResp.done);
            compareValue("fetchResp.done", 0, fetchResp.done);
            if (expReq.isStore) begin
                applyStore(expReq);
            end else begin
                compareValue("dataResp.rdata", modelWord(expReq.addr, expReq.len),
                             dataResp.rdata);
            end
        end else begin
            compareValue("fetchResp.done", 1, fetchResp.done);
            compareValue("dataResp.done", 0, dataResp.done);
            compareValue("fetchResp.rdata", modelWord(expReq.addr, `FETCH_LEN),
                         fetchResp.rdata);
        end
        pending = 1'b0;
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (rst || !pending) begin
            compareValue("fetchBusy", 0, fetchBusy);
            compareValue("dataBusy", 0, dataBusy);
            compareValue("fetchResp.done", 0, fetchResp.done);
            compareValue("dataResp.done", 0, dataResp.done);
            pending = 1'b0;
            // next edge grants, data side first
            if (!rst && rdy && !ioFull && (dataEn || fetchEn)) begin
                expOwner = dataEn ? ownData : ownFetch;
                expReq   = dataReq;
                if (!dataEn) begin
                    expReq.addr    = fetchAddr;
                    expReq.wdata   = '0;
                    expReq.len     = `LEN_W'(`FETCH_LEN);
                    expReq.isStore = 1'b0;
                end
                cycles  = 0;
                stalls  = 0;
                pending = 1'b1;
            end
        end else begin
            compareValue("fetchBusy", 1, fetchBusy);
            compareValue("dataBusy", 1, dataBusy);
            if (fetchResp.done || dataResp.done) begin
                finishTransaction();
            end else begin
                if (!rdy || ioFull) begin
                    stalls++;
                end
                cycles++;
            end
        end
    end

endmodule

/* testbench/memSubsystemTb.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module memSubsystemTb
    import memPkg::*;
();
    localparam int NumTxn       = 300;
    localparam int CyclesPerTxn = 12;
    localparam int ClkPeriod    = 8;

    logic                   clk;
    logic                   rst;
    logic                   rdy;
    logic                   ioFull;
    logic                   fetchEn;
    logic [`RAM_ADDR_W-1:0] fetchAddr;
    logic                   dataEn;
    memReq                  dataReq;
    memResp                 fetchResp;
    memResp                 dataResp;
    logic                   fetchBusy;
    logic                   dataBusy;
    int                     errorCount;
    int                     checkCount;
    int                     doneCount;
    int                     issued;
    logic                   stallOn;

    clockGen #(.HalfPeriod(ClkPeriod / 2), .ResetCycles(8)) u_clk (.clk(clk), .rst(rst));

    memSubsystem u_dut (
        .clk(clk), .rst(rst), .rdy(rdy), .ioFull(ioFull),
        .fetchEn(fetchEn), .fetchAddr(fetchAddr), .dataEn(dataEn), .dataReq(dataReq),
        .fetchResp(fetchResp), .dataResp(dataResp),
        .fetchBusy(fetchBusy), .dataBusy(dataBusy)
    );

    memChecker u_checker (
        .clk(clk), .rst(rst), .rdy(rdy), .ioFull(ioFull),
        .fetchEn(fetchEn), .fetchAddr(fetchAddr), .dataEn(dataEn), .dataReq(dataReq),
        .fetchResp(fetchResp), .dataResp(dataResp),
        .fetchBusy(fetchBusy), .dataBusy(dataBusy),
        .errorCount(errorCount), .checkCount(checkCount), .doneCount(doneCount)
    );

    // mostly a small window across the top of the ram, so accesses wrap and overlap
    function automatic logic [`RAM_ADDR_W-1:0] pickAddr();
        if ($urandom_range(0, 4) == 0) begin
            return `RAM_ADDR_W'($urandom);
        end
        return `RAM_ADDR_W'($urandom_range(0, 63) - 32);
    endfunction

    // enables held until each side's done, data side answered first
    task automatic runRequest(input logic useData, input logic useFetch, input memReq r,
                              input logic [`RAM_ADDR_W-1:0] fa);
        @(posedge clk);
        dataEn    <= useData;
        dataReq   <= r;
        fetchEn   <= useFetch;
        fetchAddr <= fa;
        if (useData) begin
            do @(negedge clk); while (!dataResp.done);
            @(posedge clk);
            dataEn <= 1'b0;
        end
        if (useFetch) begin
            do @(negedge clk); while (!fetchResp.done);
            @(posedge clk);
            fetchEn <= 1'b0;
        end
    endtask

    initial begin
        memReq r;
        int    kind;
        void'($urandom(55392));
        rdy       = 1'b1;
        ioFull    = 1'b0;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        dataEn    = 1'b0;
        dataReq   = '0;
        stallOn   = 1'b0;
        issued    = 0;
        fork
            forever begin
                @(posedge clk);
                rdy    <= !stallOn || ($urandom_range(0, 7) != 0);
                ioFull <= stallOn && ($urandom_range(0, 11) == 0);
            end
        join_none
        wait (rst == 1'b0);
        repeat (2) @(posedge clk);
        for (int i = 0; i < NumTxn; i++) begin
            // first third runs without pauses for clean latency
            stallOn   = (i >= NumTxn / 3);
            kind      = $urandom_range(0, 9);
            r.addr    = pickAddr();
            r.wdata   = $urandom;
            r.len     = `LEN_W'(1 << $urandom_range(0, 2));
            r.isStore = $urandom_range(0, 1);
            runRequest(kind >= 3, kind < 3 || kind == 9, r, pickAddr());
            issued += (kind >= 3) + (kind < 3 || kind == 9);
            repeat ($urandom_range(0, 2)) @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("transactions: %0d issued, %0d done; checks: %0d; errors: %0d",
                 issued, doneCount, checkCount, errorCount);
        if (errorCount == 0 && doneCount == issued) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(NumTxn * CyclesPerTxn * ClkPeriod);
        $display("timeout: transactions still running after %0d ns",
                 NumTxn * CyclesPerTxn * ClkPeriod);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
